// File: src/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;

    typedef logic [31:0] pc_t;
    typedef logic [4:0] reg_addr_t;

    localparam pc_t start_addr = 32'h0000_0000;

    // base opcodes of the supported subset
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // a7 service numbers and the exit code for bad instructions
    localparam logic [7:0] ecall_print = 8'd1;
    localparam logic [7:0] ecall_exit = 8'd93;
    localparam logic [7:0] exit_illegal = 8'hff;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } i_fmt_t;

    // branch offset bits are scattered around rs1/rs2
    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        reg_addr_t rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jal
    } branch_t;

    typedef struct packed {
        pc_t pc;
        logic epoch;
        inst_word_t inst;
    } fetch_item_t;

    typedef struct packed {
        pc_t pc;
        logic epoch;
        alu_op_t alu_op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        branch_t branch;
        pc_t target;
        reg_addr_t rd;
        logic write_enable;
        logic ecall;
    } execute_op_t;

    typedef struct packed {
        logic valid;
        pc_t target;
    } jump_cmd_t;

    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        logic [xlen-1:0] value;
    } writeback_t;

    typedef struct packed {
        logic [7:0] kind;
        logic [xlen-1:0] value;
    } ecall_cmd_t;

endpackage

// File: src/core_fetch.sv
`timescale 1ns/10ps

module core_fetch (
    input logic clk,
    input logic reset,
    input logic decode_ready,
    input core_pkg::jump_cmd_t jump,
    input logic halt,
    output logic inst_req_valid,
    output core_pkg::pc_t inst_req_addr,
    input logic inst_rsp_valid,
    input logic [31:0] inst_rsp_data,
    output logic fetch_valid,
    output core_pkg::fetch_item_t fetch_item
);

    core_pkg::pc_t pc;
    core_pkg::pc_t req_pc;
    logic pending;
    logic epoch;
    logic req_epoch;

    // one request in flight, and only if decode can take the answer
    assign inst_req_valid = decode_ready && !pending && !halt;
    assign inst_req_addr = pc;

    assign fetch_valid = pending && inst_rsp_valid;

    always_comb begin
        fetch_item.pc = req_pc;
        fetch_item.epoch = req_epoch;
        fetch_item.inst = inst_rsp_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= core_pkg::start_addr;
            pending <= 1'b0;
            epoch <= 1'b0;
        end else begin
            // memory latency is fixed at one cycle
            pending <= inst_req_valid;
            if (jump.valid) begin
                pc <= jump.target;
                epoch <= ~epoch;
            end else if (inst_req_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // a request made during a redirect keeps the old epoch
    always_ff @(posedge clk) begin
        if (inst_req_valid) begin
            req_pc <= pc;
            req_epoch <= epoch;
        end
    end

endmodule

// File: src/core_decode.sv
`timescale 1ns/10ps

module core_decode (
    input logic clk,
    input logic reset,
    input logic fetch_valid,
    input core_pkg::fetch_item_t fetch_item,
    output logic decode_ready,
    input core_pkg::jump_cmd_t jump,
    input core_pkg::writeback_t writeback,
    output logic issue_valid,
    output core_pkg::execute_op_t execute_op,
    input logic execute_ready
);

    logic item_valid;
    core_pkg::fetch_item_t item;
    logic epoch;
    logic [core_pkg::xlen-1:0] regs [1:31];
    logic [31:0] busy;
    logic [31:0] set_mask;
    logic [31:0] clear_mask;

    core_pkg::inst_word_t inst;
    logic [6:0] opcode;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    logic uses_rs1;
    logic uses_rs2;
    logic illegal;
    logic [core_pkg::xlen-1:0] rs1_value;
    logic [core_pkg::xlen-1:0] rs2_value;
    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_b;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] imm_j;
    logic live;
    logic hazard;
    logic fire;

    assign inst = item.inst;
    assign opcode = inst.r_fmt.opcode;
    assign live = item_valid && (item.epoch == epoch);

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

    // ecall reads a0 and a7 instead of the encoded fields
    assign rs1 = (opcode == core_pkg::op_system) ? 5'd10 : inst.r_fmt.rs1;
    assign rs2 = (opcode == core_pkg::op_system) ? 5'd17 : inst.r_fmt.rs2;
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_comb begin
        execute_op = '0;
        execute_op.pc = item.pc;
        execute_op.epoch = item.epoch;
        execute_op.rd = inst.r_fmt.rd;
        execute_op.a = rs1_value;
        execute_op.b = rs2_value;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        illegal = 1'b0;
        case (opcode)
            core_pkg::op_imm: begin
                uses_rs1 = 1'b1;
                execute_op.b = imm_i;
                execute_op.write_enable = (inst.i_fmt.rd != 5'd0);
                case (inst.i_fmt.funct3)
                    3'b100: execute_op.alu_op = core_pkg::alu_xor;
                    3'b110: execute_op.alu_op = core_pkg::alu_or;
                    3'b111: execute_op.alu_op = core_pkg::alu_and;
                    default: execute_op.alu_op = core_pkg::alu_add;
                endcase
            end
            core_pkg::op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                execute_op.write_enable = (inst.r_fmt.rd != 5'd0);
                case (inst.r_fmt.funct3)
                    3'b000: begin
                        execute_op.alu_op = inst.r_fmt.funct7[5] ?
                            core_pkg::alu_sub : core_pkg::alu_add;
                    end
                    3'b100: execute_op.alu_op = core_pkg::alu_xor;
                    3'b110: execute_op.alu_op = core_pkg::alu_or;
                    3'b111: execute_op.alu_op = core_pkg::alu_and;
                    default: illegal = 1'b1;
                endcase
            end
            core_pkg::op_lui: begin
                execute_op.alu_op = core_pkg::alu_pass_b;
                execute_op.b = imm_u;
                execute_op.write_enable = (inst.u_fmt.rd != 5'd0);
            end
            core_pkg::op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                execute_op.target = item.pc + imm_b;
                case (inst.b_fmt.funct3)
                    3'b000: execute_op.branch = core_pkg::br_eq;
                    3'b001: execute_op.branch = core_pkg::br_ne;
                    default: illegal = 1'b1;
                endcase
            end
            core_pkg::op_jal: begin
                // link value pc+4 comes out of the adder
                execute_op.a = item.pc;
                execute_op.b = 32'd4;
                execute_op.branch = core_pkg::br_jal;
                execute_op.target = item.pc + imm_j;
                execute_op.write_enable = (inst.j_fmt.rd != 5'd0);
            end
            core_pkg::op_system: begin
                if (inst.i_fmt.imm == 12'd0 && inst.i_fmt.funct3 == 3'd0) begin
                    execute_op.ecall = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        // anything unknown leaves as an exit call with a fault code
        if (illegal) begin
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
            execute_op.alu_op = core_pkg::alu_add;
            execute_op.branch = core_pkg::br_none;
            execute_op.write_enable = 1'b0;
            execute_op.ecall = 1'b1;
            execute_op.a = {{(core_pkg::xlen-8){1'b0}}, core_pkg::exit_illegal};
            execute_op.b = {{(core_pkg::xlen-8){1'b0}}, core_pkg::ecall_exit};
        end
    end

    assign hazard = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) ||
                    (execute_op.ecall && (busy != 32'd0));
    // nothing issues in the redirect cycle, that item is on the wrong path
    assign issue_valid = live && !hazard && !jump.valid;
    assign fire = issue_valid && execute_ready;
    assign decode_ready = !live || fire;

    always_comb begin
        set_mask = 32'd0;
        clear_mask = 32'd0;
        if (fire && execute_op.write_enable) begin
            set_mask[execute_op.rd] = 1'b1;
        end
        if (writeback.valid) begin
            clear_mask[writeback.rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
            epoch <= 1'b0;
            busy <= 32'd0;
        end else begin
            if (decode_ready) begin
                item_valid <= fetch_valid;
            end
            if (jump.valid) begin
                epoch <= ~epoch;
            end
            busy <= (busy & ~clear_mask) | set_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_ready) begin
            item <= fetch_item;
        end
        if (writeback.valid && writeback.rd != 5'd0) begin
            regs[writeback.rd] <= writeback.value;
        end
    end

endmodule

// File: src/core_execute.sv
`timescale 1ns/10ps

module core_execute (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input core_pkg::execute_op_t execute_op,
    output logic execute_ready,
    output core_pkg::writeback_t writeback,
    output core_pkg::jump_cmd_t jump,
    output logic ecall_valid,
    output core_pkg::ecall_cmd_t ecall_cmd,
    input logic ecall_ready
);

    logic op_valid;
    core_pkg::execute_op_t op;
    logic [core_pkg::xlen-1:0] result;
    logic taken;

    // an ecall sits in the op register until the ecall unit takes it
    assign execute_ready = !(op_valid && op.ecall) || ecall_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (execute_ready) begin
            op_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (execute_ready) begin
            op <= execute_op;
        end
    end

    always_comb begin
        case (op.alu_op)
            core_pkg::alu_add: result = op.a + op.b;
            core_pkg::alu_sub: result = op.a - op.b;
            core_pkg::alu_and: result = op.a & op.b;
            core_pkg::alu_or: result = op.a | op.b;
            core_pkg::alu_xor: result = op.a ^ op.b;
            core_pkg::alu_pass_b: result = op.b;
            default: result = '0;
        endcase
    end

    // not-taken is the fall-through path, so only taken branches redirect
    always_comb begin
        case (op.branch)
            core_pkg::br_eq: taken = (op.a == op.b);
            core_pkg::br_ne: taken = (op.a != op.b);
            core_pkg::br_jal: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump.valid = op_valid && taken;
        jump.target = op.target;
    end

    always_comb begin
        writeback.valid = op_valid && op.write_enable;
        writeback.rd = op.rd;
        writeback.value = result;
    end

    // a7 low byte selects the service, a0 is the argument
    always_comb begin
        ecall_valid = op_valid && op.ecall;
        ecall_cmd.kind = op.b[7:0];
        ecall_cmd.value = op.a;
    end

endmodule

// File: src/core_ecall_unit.sv
`timescale 1ns/10ps

module core_ecall_unit (
    input logic clk,
    input logic reset,
    input logic ecall_valid,
    input core_pkg::ecall_cmd_t ecall_cmd,
    output logic ecall_ready,
    output logic print_valid,
    output logic [7:0] print_data,
    input logic print_ready,
    output logic finished,
    output logic faulted,
    output logic halt
);

    logic done;
    logic accept;
    logic is_print;
    logic is_exit;

    assign done = finished || faulted;
    assign halt = done;

    // take a call once the character register drains, never after exit
    assign ecall_ready = !done && (!print_valid || print_ready);
    assign accept = ecall_valid && ecall_ready;

    assign is_print = (ecall_cmd.kind == core_pkg::ecall_print);
    assign is_exit = (ecall_cmd.kind == core_pkg::ecall_exit);

    always_ff @(posedge clk) begin
        if (reset) begin
            print_valid <= 1'b0;
            finished <= 1'b0;
            faulted <= 1'b0;
        end else begin
            if (print_valid && print_ready) begin
                print_valid <= 1'b0;
            end
            if (accept && is_print) begin
                print_valid <= 1'b1;
            end
            if (accept && is_exit) begin
                // zero exit code is a clean finish
                if (ecall_cmd.value == '0) begin
                    finished <= 1'b1;
                end else begin
                    faulted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_print) begin
            print_data <= ecall_cmd.value[7:0];
        end
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/10ps

module core_top (
    input logic clk,
    input logic reset,
    output logic inst_req_valid,
    output core_pkg::pc_t inst_req_addr,
    input logic inst_rsp_valid,
    input logic [31:0] inst_rsp_data,
    output logic print_valid,
    output logic [7:0] print_data,
    input logic print_ready,
    output logic finished,
    output logic faulted
);

    logic fetch_valid;
    logic decode_ready;
    core_pkg::fetch_item_t fetch_item;

    logic issue_valid;
    logic execute_ready;
    core_pkg::execute_op_t execute_op;

    core_pkg::jump_cmd_t jump;
    core_pkg::writeback_t writeback;

    logic ecall_valid;
    logic ecall_ready;
    core_pkg::ecall_cmd_t ecall_cmd;
    logic halt;

    core_fetch core_fetch_inst (
        .clk, .reset,
        .decode_ready, .jump, .halt,
        .inst_req_valid, .inst_req_addr,
        .inst_rsp_valid, .inst_rsp_data,
        .fetch_valid, .fetch_item
    );

    core_decode core_decode_inst (
        .clk, .reset,
        .fetch_valid, .fetch_item, .decode_ready,
        .jump, .writeback,
        .issue_valid, .execute_op, .execute_ready
    );

    core_execute core_execute_inst (
        .clk, .reset,
        .issue_valid, .execute_op, .execute_ready,
        .writeback, .jump,
        .ecall_valid, .ecall_cmd, .ecall_ready
    );

    core_ecall_unit core_ecall_unit_inst (
        .clk, .reset,
        .ecall_valid, .ecall_cmd, .ecall_ready,
        .print_valid, .print_data, .print_ready,
        .finished, .faulted, .halt
    );

endmodule

// File: verification/core_tb_programs.svh
// a7 = 1 selects the print service
task automatic select_print();
    append_word(addi_inst(5'd17, 5'd0, 12'd1));
endtask

task automatic print_char(input logic [7:0] c);
    append_word(addi_inst(5'd10, 5'd0, {4'd0, c}));
    append_word(ecall_inst());
endtask

task automatic print_register(input logic [4:0] r);
    append_word(addi_inst(5'd10, r, 12'd0));
    append_word(ecall_inst());
endtask

task automatic exit_with(input logic [7:0] code);
    append_word(addi_inst(5'd10, 5'd0, {4'd0, code}));
    append_word(addi_inst(5'd17, 5'd0, 12'd93));
    append_word(ecall_inst());
endtask

// reset arrives while a character is still waiting for print_ready
task automatic reset_state_test();
    start_program();
    select_print();
    print_char("r");
    exit_with(8'd0);
    cycle_limit += prog_len * 20;
    hold_ready = 1'b1;
    apply_reset();
    while (!print_valid) begin
        @(negedge clk);
    end
    start_program();
    exit_with(8'd0);
    run_program(1'b1, 1'b0);
    hold_ready = 1'b0;
endtask

// each op reads results of the ops before it
task automatic alu_chain_test();
    logic [31:0] r [1:8];
    start_program();
    select_print();
    r[1] = 32'h41;
    append_word(addi_inst(5'd1, 5'd0, 12'h041));
    r[2] = r[1] + 32'd3;
    append_word(addi_inst(5'd2, 5'd1, 12'd3));
    r[3] = r[1] + r[2];
    append_word(rr_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    r[4] = r[1] - r[3];
    append_word(rr_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd3));
    r[5] = r[3] & r[2];
    append_word(rr_word(7'h00, 3'b111, 5'd5, 5'd3, 5'd2));
    r[6] = r[5] | r[4];
    append_word(rr_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd4));
    r[7] = r[6] ^ r[3];
    append_word(rr_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd3));
    r[8] = r[7] - 32'd5;
    append_word(addi_inst(5'd8, 5'd7, 12'hffb));
    for (int i = 1; i <= 8; i++) begin
        print_register(5'(i));
        exp_chars.push_back(r[i][7:0]);
    end
    exit_with(8'd0);
    run_program(1'b1, 1'b0);
endtask

task automatic lui_branch_test();
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] sum;
    x1 = {20'h12345, 12'h000};
    x2 = {20'h12345, 12'h000};
    x3 = {20'h12346, 12'h000};
    sum = x1 + 32'h4c;
    start_program();
    select_print();
    append_word(lui_inst(5'd1, 20'h12345));
    append_word(lui_inst(5'd2, 20'h12345));
    append_word(branch_word(3'b000, 5'd1, 5'd2, 13'd12));
    print_char("X");
    print_char("b");
    append_word(branch_word(3'b001, 5'd1, 5'd2, 13'd12));
    print_char("n");
    append_word(lui_inst(5'd3, 20'h12346));
    append_word(branch_word(3'b001, 5'd1, 5'd3, 13'd12));
    print_char("Y");
    append_word(branch_word(3'b000, 5'd1, 5'd3, 13'd12));
    print_register(5'd0);
    // replace the x0 print with a0 = x1 + 0x4c
    mem[prog_len - 2] = addi_inst(5'd10, 5'd1, 12'h04c);
    exit_with(8'd0);
    if (!(x1 == x2)) exp_chars.push_back("X");
    exp_chars.push_back("b");
    if (!(x1 != x2)) exp_chars.push_back("n");
    if (!(x1 != x3)) exp_chars.push_back("Y");
    if (!(x1 == x3)) exp_chars.push_back(sum[7:0]);
    run_program(1'b1, 1'b0);
endtask

task automatic jal_test();
    logic [31:0] link;
    start_program();
    select_print();
    append_word(addi_inst(5'd5, 5'd0, 12'h030));
    link = (prog_len * 4) + 4;
    append_word(jal_inst(5'd1, 21'd12));
    print_char("Z");
    print_register(5'd1);
    print_register(5'd5);
    exit_with(8'd0);
    exp_chars.push_back(link[7:0]);
    exp_chars.push_back(8'h30);
    run_program(1'b1, 1'b0);
endtask

task automatic backpressure_test();
    logic [7:0] c;
    start_program();
    select_print();
    for (int i = 0; i < 16; i++) begin
        c = 8'h61 + 8'(i);
        print_char(c);
        exp_chars.push_back(c);
    end
    exit_with(8'd0);
    random_ready = 1'b1;
    run_program(1'b1, 1'b0);
    random_ready = 1'b0;
endtask

task automatic exit_test();
    logic [7:0] code;
    code = 8'd0;
    start_program();
    select_print();
    print_char("!");
    exit_with(code);
    print_char("?");
    exp_chars.push_back("!");
    run_program(code == 8'd0, code != 8'd0);
    code = 8'd7;
    start_program();
    select_print();
    print_char("k");
    exit_with(code);
    print_char("Q");
    exp_chars.push_back("k");
    run_program(code == 8'd0, code != 8'd0);
    // load-fp opcode is outside the subset
    code = 8'hff;
    start_program();
    select_print();
    print_char("i");
    append_word(32'h0000_0007);
    print_char("W");
    exp_chars.push_back("i");
    run_program(code == 8'd0, code != 8'd0);
endtask

// File: verification/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    logic clk;
    logic reset;
    logic inst_req_valid;
    core_pkg::pc_t inst_req_addr;
    logic inst_rsp_valid;
    logic [31:0] inst_rsp_data;
    logic print_valid;
    logic [7:0] print_data;
    logic print_ready;
    logic finished;
    logic faulted;

    logic [31:0] mem [0:255];
    int prog_len;
    logic req_seen;
    core_pkg::pc_t req_addr;
    logic random_ready;
    logic hold_ready;
    logic [15:0] lfsr;
    logic [7:0] got_chars [$];
    logic [7:0] exp_chars [$];
    int checks;
    int errors;
    int cycle_count;
    int cycle_limit;

    core_top DUT (
        .clk, .reset,
        .inst_req_valid, .inst_req_addr,
        .inst_rsp_valid, .inst_rsp_data,
        .print_valid, .print_data, .print_ready,
        .finished, .faulted
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // unused words decode as illegal and carry their index
    function automatic logic [31:0] fill_word(input int idx);
        return {idx[24:0], 7'b1111111};
    endfunction

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rr_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // byte offset whose bit 0 the format drops
    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] ecall_inst();
        return 32'h0000_0073;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic start_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        prog_len = 0;
        exp_chars.delete();
    endtask

    task automatic append_word(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic run_program(input logic exp_finished, input logic exp_faulted);
        cycle_limit += prog_len * 20;
        got_chars.delete();
        apply_reset();
        @(negedge clk);
        check_value("print_valid", {31'd0, print_valid}, 32'd0);
        check_value("finished", {31'd0, finished}, 32'd0);
        check_value("faulted", {31'd0, faulted}, 32'd0);
        check_value("inst_req_valid", {31'd0, inst_req_valid}, 32'd1);
        check_value("inst_req_addr", inst_req_addr, 32'd0);
        while (!(finished || faulted)) begin
            @(negedge clk);
        end
        // flags must hold and fetch must stay quiet
        repeat (20) begin
            @(negedge clk);
            check_value("finished", {31'd0, finished}, {31'd0, exp_finished});
            check_value("faulted", {31'd0, faulted}, {31'd0, exp_faulted});
            check_value("inst_req_valid", {31'd0, inst_req_valid}, 32'd0);
        end
        check_true(got_chars.size() == exp_chars.size(),
                   $sformatf("wrong number of printed characters, got %0d expected %0d",
                             got_chars.size(), exp_chars.size()));
        for (int i = 0; i < exp_chars.size() && i < got_chars.size(); i++) begin
            check_value("print_data", {24'd0, got_chars[i]}, {24'd0, exp_chars[i]});
        end
    endtask

    `include "core_tb_programs.svh"

    // instruction memory answers one cycle after each request
    always begin
        @(negedge clk);
        req_seen = inst_req_valid && !reset;
        req_addr = inst_req_addr;
        @(posedge clk);
        #1;
        inst_rsp_valid = req_seen;
        inst_rsp_data = req_seen ? mem[req_addr[9:2]] : 32'd0;
    end

    always begin
        @(posedge clk);
        #1;
        if (hold_ready) begin
            print_ready = 1'b0;
        end else if (random_ready) begin
            print_ready = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            print_ready = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (print_valid && print_ready) begin
                got_chars.push_back(print_data);
            end
            if (finished || faulted) begin
                check_true(!print_valid, "a character was offered after the exit call");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the program never reached its exit",
                     cycle_count);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst_rsp_valid = 1'b0;
        inst_rsp_data = 32'd0;
        print_ready = 1'b1;
        random_ready = 1'b0;
        hold_ready = 1'b0;
        lfsr = 16'd15;
        prog_len = 0;
        checks = 0;
        errors = 0;
        cycle_count = 0;
        cycle_limit = 2000;
        reset_state_test();
        alu_chain_test();
        lui_branch_test();
        jal_test();
        backpressure_test();
        exit_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verification
src/core_pkg.sv
src/core_fetch.sv
src/core_decode.sv
src/core_execute.sv
src/core_ecall_unit.sv
src/core_top.sv
verification/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module core_tb -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcore_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
